/* verilog/regex_pkg.sv */
`default_nettype none

package regex_pkg;

   // Stream identifier width and stream count
   localparam int STREAM_W = 6;
   localparam int NUM_STREAMS = 64;

   // Shift-and state width, also the longest pattern accepted
   localparam int STATE_W = 11;

   // Packet match counter width
   localparam int COUNT_W = 16;

   // Category blocks in the top level
   localparam int NUM_CAT = 2;

   // One input byte
   typedef logic [7:0] char_t;

   // Stream identifier as carried with sop
   typedef logic [STREAM_W-1:0] stream_id_t;

   // Bit i set means the last i+1 bytes match the pattern prefix
   typedef logic [STATE_W-1:0] match_state_t;

   // Count of packets holding at least one match
   typedef logic [COUNT_W-1:0] match_count_t;

   // One bit per category
   typedef logic [NUM_CAT-1:0] cat_mask_t;

endpackage

`default_nettype wire

/* verilog/shift_and_matcher.sv */
`default_nettype none

module shift_and_matcher #(
   // Pattern bytes, first byte in the low byte
   parameter logic [8*regex_pkg::STATE_W-1:0] PATTERN = '0,
   // Active pattern length, 1 to STATE_W
   parameter int PAT_LEN = 1
) (
   input  logic                    clk,
   input  logic                    rst_n,
   // Overwrite of the state at start of packet
   input  logic                    state_load,
   input  regex_pkg::match_state_t state_in,
   // Byte stream
   input  logic                    char_vld,
   input  regex_pkg::char_t        char_in,
   // Current state and registered match pulse
   output regex_pkg::match_state_t state_out,
   output logic                    accept_out
);

   // Positions where the pattern byte equals the incoming byte
   regex_pkg::match_state_t char_mask;

   // Positions inside the active pattern length
   regex_pkg::match_state_t len_mask;

   // State after the current byte
   regex_pkg::match_state_t state_next;

   // Per-position byte compare
   always_comb
   begin
      for (int i = 0; i < regex_pkg::STATE_W; i++)
      begin
         char_mask[i] = (PATTERN[8*i +: 8] == char_in);
         // Upper positions stay clear for short patterns
         len_mask[i] = (i < PAT_LEN);
      end
   end

   // Shift-and step
   always_comb
   begin
      // Every byte may start a new match, so bit 0 is fed a one
      state_next = (state_out << 1) | regex_pkg::match_state_t'(1);
      // Keep only prefixes still matching
      state_next = state_next & char_mask & len_mask;
   end

   // State register and accept pulse
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out  <= '0;
         accept_out <= 1'b0;
      end
      else
      begin
         // Accept is a one-cycle pulse per matching byte
         accept_out <= 1'b0;
         if (state_load)
         begin
            // Restored or cleared state for the new packet
            state_out <= state_in;
         end
         else if (char_vld)
         begin
            state_out <= state_next;
            // Full pattern seen when the top active bit is set
            accept_out <= state_next[PAT_LEN-1];
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/stream_tracker.sv */
`default_nettype none

module stream_tracker (
   input  logic                  clk,
   input  logic                  rst_n,
   // Start of packet with its stream
   input  logic                  sop,
   input  regex_pkg::stream_id_t stream_id,
   // Enable table write port
   input  logic                  cfg_we,
   input  regex_pkg::stream_id_t cfg_stream,
   input  regex_pkg::cat_mask_t  cfg_enable,
   // Context of the open packet
   output logic                  load_state,
   output logic                  new_stream,
   output regex_pkg::stream_id_t cur_stream,
   output regex_pkg::cat_mask_t  cur_enable
);

   // One bit per stream, set once the stream has had a packet
   logic [regex_pkg::NUM_STREAMS-1:0] seen;

   // Per-stream category enables
   regex_pkg::cat_mask_t en_tbl [regex_pkg::NUM_STREAMS];

   // Enable table
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         // All categories off for every stream
         for (int i = 0; i < regex_pkg::NUM_STREAMS; i++)
         begin
            en_tbl[i] <= '0;
         end
      end
      else if (cfg_we)
      begin
         en_tbl[cfg_stream] <= cfg_enable;
      end
   end

   // Seen bits and packet context
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen       <= '0;
         load_state <= 1'b0;
         new_stream <= 1'b0;
         cur_stream <= '0;
         cur_enable <= '0;
      end
      else
      begin
         // Single-cycle load pulse
         load_state <= sop;
         if (sop)
         begin
            // Context holds until the next sop
            cur_stream <= stream_id;
            cur_enable <= en_tbl[stream_id];
            // First packet of this stream since reset
            new_stream <= ~seen[stream_id];
            seen[stream_id] <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/regex_category.sv */
`default_nettype none

module regex_category #(
   // Pattern bytes, first byte in the low byte
   parameter logic [8*regex_pkg::STATE_W-1:0] PATTERN = '0,
   // Active pattern length
   parameter int PAT_LEN = 1
) (
   input  logic                    clk,
   input  logic                    rst_n,
   // Start of packet context from the tracker
   input  logic                    load_state,
   input  logic                    new_stream,
   input  regex_pkg::stream_id_t   cur_stream,
   // This category's enable bit for the current stream
   input  logic                    enable,
   // Byte stream
   input  logic                    char_vld,
   input  regex_pkg::char_t        char_in,
   // End of packet strobe
   input  logic                    eop,
   // Packets with a match, in enabled streams
   output regex_pkg::match_count_t count,
   // Match seen in the current packet
   output logic                    fired
);

   // Saved matcher state, one entry per stream
   regex_pkg::match_state_t state_mem [regex_pkg::NUM_STREAMS];

   // Load path into the matcher
   logic                    state_load;
   regex_pkg::match_state_t state_in;

   // Matcher results
   regex_pkg::match_state_t state_out;
   logic                    accept_out;

   // Load strobe to the matcher, one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_load <= 1'b0;
      end
      else
      begin
         state_load <= load_state;
      end
   end

   // State restore and save
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream)
         begin
            // Unknown stream starts from zero
            state_in <= '0;
            // Clear its slot so a later restore is defined
            state_mem[cur_stream] <= '0;
         end
         else
         begin
            // Resume the partial match of this stream
            state_in <= state_mem[cur_stream];
         end
      end
      // Save state only in enabled streams
      if (eop && enable)
      begin
         state_mem[cur_stream] <= state_out;
      end
   end

   // Speculative match flag and packet counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
         fired <= 1'b0;
      end
      else
      begin
         // New packet, no match yet
         if (load_state)
         begin
            fired <= 1'b0;
         end
         // Any match in the packet sets the flag
         if (accept_out)
         begin
            fired <= 1'b1;
         end
         // Commit at end of packet
         if (eop)
         begin
            if (enable)
            begin
               // At most one count per packet
               count <= count + regex_pkg::match_count_t'(fired);
            end
            else
            begin
               // Disabled stream, drop the result
               fired <= 1'b0;
            end
         end
      end
   end

   shift_and_matcher #(
      .PATTERN (PATTERN),
      .PAT_LEN (PAT_LEN)
   ) u_matcher (
      .clk        (clk),
      .rst_n      (rst_n),
      .state_load (state_load),
      .state_in   (state_in),
      .char_vld   (char_vld),
      .char_in    (char_in),
      .state_out  (state_out),
      .accept_out (accept_out)
   );

endmodule

`default_nettype wire

/* verilog/regex_scan_top.sv */
`default_nettype none

module regex_scan_top #(
   // Category A pattern, "abc" low byte first
   parameter logic [8*regex_pkg::STATE_W-1:0] PATTERN_A = 88'h636261,
   parameter int PAT_LEN_A = 3,
   // Category B pattern, "needle" low byte first
   parameter logic [8*regex_pkg::STATE_W-1:0] PATTERN_B = 88'h656c6465656e,
   parameter int PAT_LEN_B = 6
) (
   input  logic                    clk,
   input  logic                    rst_n,
   // Packet framing and bytes
   input  logic                    sop,
   input  regex_pkg::stream_id_t   stream_id,
   input  logic                    char_vld,
   input  regex_pkg::char_t        char_in,
   input  logic                    eop,
   // Enable configuration
   input  logic                    cfg_we,
   input  regex_pkg::stream_id_t   cfg_stream,
   input  regex_pkg::cat_mask_t    cfg_enable,
   // Results
   output regex_pkg::match_count_t count_a,
   output regex_pkg::match_count_t count_b,
   output regex_pkg::cat_mask_t    fired
);

   // Packet context shared by both categories
   logic                  load_state;
   logic                  new_stream;
   regex_pkg::stream_id_t cur_stream;
   regex_pkg::cat_mask_t  cur_enable;

   stream_tracker u_tracker (
      .clk        (clk),
      .rst_n      (rst_n),
      .sop        (sop),
      .stream_id  (stream_id),
      .cfg_we     (cfg_we),
      .cfg_stream (cfg_stream),
      .cfg_enable (cfg_enable),
      .load_state (load_state),
      .new_stream (new_stream),
      .cur_stream (cur_stream),
      .cur_enable (cur_enable)
   );

   // Category A takes enable bit 0
   regex_category #(
      .PATTERN (PATTERN_A),
      .PAT_LEN (PAT_LEN_A)
   ) u_cat_a (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (load_state),
      .new_stream (new_stream),
      .cur_stream (cur_stream),
      .enable     (cur_enable[0]),
      .char_vld   (char_vld),
      .char_in    (char_in),
      .eop        (eop),
      .count      (count_a),
      .fired      (fired[0])
   );

   // Category B takes enable bit 1
   regex_category #(
      .PATTERN (PATTERN_B),
      .PAT_LEN (PAT_LEN_B)
   ) u_cat_b (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_state (load_state),
      .new_stream (new_stream),
      .cur_stream (cur_stream),
      .enable     (cur_enable[1]),
      .char_vld   (char_vld),
      .char_in    (char_in),
      .eop        (eop),
      .count      (count_b),
      .fired      (fired[1])
   );

endmodule

`default_nettype wire

/* dv/regex_scan_chk.sv */
`default_nettype none

module regex_scan_chk (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    sop,
   input  logic                    char_vld,
   input  logic                    eop,
   input  regex_pkg::match_count_t count_a,
   input  regex_pkg::match_count_t count_b,
   input  regex_pkg::cat_mask_t    fired
);

   // Load after sop clears both flags
   fired_clear_after_sop: assert property (@(posedge clk) disable iff (!rst_n)
      $past(sop, 2) |-> fired == '0)
      else $error("fired still set two cycles after sop");

   // Matcher state is not loaded before the third cycle
   no_early_char: assert property (@(posedge clk) disable iff (!rst_n)
      char_vld |-> !sop && !$past(sop) && !$past(sop, 2))
      else $error("char_vld within three cycles of sop");

   // Count A moves only right after eop, one step at a time
   count_a_step: assert property (@(posedge clk) disable iff (!rst_n)
      count_a != $past(count_a) |->
         $past(eop) && count_a == regex_pkg::match_count_t'($past(count_a) + 1))
      else $error("count_a changed outside eop or by more than one");

   // Same rule for count B
   count_b_step: assert property (@(posedge clk) disable iff (!rst_n)
      count_b != $past(count_b) |->
         $past(eop) && count_b == regex_pkg::match_count_t'($past(count_b) + 1))
      else $error("count_b changed outside eop or by more than one");

endmodule

`default_nettype wire

/* dv/regex_scan_tb.sv */
`default_nettype none

module regex_scan_tb;

   // Clock period and watchdog budget
   localparam int CLK_PERIOD     = 4;
   localparam int NUM_PACKETS    = 20;
   localparam int MAX_PKT_CYCLES = 40;
   localparam int MARGIN_CYCLES  = 200;

   logic                    clk;
   logic                    rst_n;
   logic                    sop;
   regex_pkg::stream_id_t   stream_id;
   logic                    char_vld;
   regex_pkg::char_t        char_in;
   logic                    eop;
   logic                    cfg_we;
   regex_pkg::stream_id_t   cfg_stream;
   regex_pkg::cat_mask_t    cfg_enable;
   regex_pkg::match_count_t count_a;
   regex_pkg::match_count_t count_b;
   regex_pkg::cat_mask_t    fired;

   // Reference model keeping the last PAT_LEN-1 bytes of each enabled stream
   string  pat [regex_pkg::NUM_CAT];
   string  hist [regex_pkg::NUM_STREAMS][regex_pkg::NUM_CAT];
   bit     seen [regex_pkg::NUM_STREAMS];
   bit     en_model [regex_pkg::NUM_STREAMS][regex_pkg::NUM_CAT];
   int     exp_count [regex_pkg::NUM_CAT];
   bit     exp_fired [regex_pkg::NUM_CAT];

   integer seed;
   int     errors;

   // Patterns "abc" and "needle" with the first byte low
   regex_scan_top #(
      .PATTERN_A (88'h636261),
      .PAT_LEN_A (3),
      .PATTERN_B (88'h656c6465656e),
      .PAT_LEN_B (6)
   ) DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .sop        (sop),
      .stream_id  (stream_id),
      .char_vld   (char_vld),
      .char_in    (char_in),
      .eop        (eop),
      .cfg_we     (cfg_we),
      .cfg_stream (cfg_stream),
      .cfg_enable (cfg_enable),
      .count_a    (count_a),
      .count_b    (count_b),
      .fired      (fired)
   );

   bind regex_scan_top regex_scan_chk u_chk (
      .clk      (clk),
      .rst_n    (rst_n),
      .sop      (sop),
      .char_vld (char_vld),
      .eop      (eop),
      .count_a  (count_a),
      .count_b  (count_b),
      .fired    (fired)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Watchdog sized from packet count and worst packet length
   initial
   begin
      #(CLK_PERIOD * (NUM_PACKETS * MAX_PKT_CYCLES + MARGIN_CYCLES));
      $display("Timeout: tests did not finish within the watchdog limit");
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

   task automatic check_value(input string what, input int got, input int expected);
      if (got != expected)
      begin
         errors++;
         $display("MISMATCH at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
         $display("Checks failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic compare_outputs(input string tag);
      check_value({tag, " count_a"}, int'(count_a), exp_count[0]);
      check_value({tag, " count_b"}, int'(count_b), exp_count[1]);
      check_value({tag, " fired[0]"}, int'(fired[0]), int'(exp_fired[0]));
      check_value({tag, " fired[1]"}, int'(fired[1]), int'(exp_fired[1]));
   endtask

   // 1 to 6 letters that appear in neither pattern
   function automatic string filler();
      string letters;
      string s;
      int    len;
      int    idx;
      int    i;
      letters = "fghijkmopqrstuvwxyz";
      s = "";
      len = 1 + int'($unsigned($random(seed)) % 6);
      for (i = 0; i < len; i++)
      begin
         idx = int'($unsigned($random(seed)) % 19);
         s = $sformatf("%s%c", s, letters[idx]);
      end
      return s;
   endfunction

   task automatic clear_model();
      int i;
      for (i = 0; i < regex_pkg::NUM_STREAMS; i++)
      begin
         seen[i] = 1'b0;
         en_model[i][0] = 1'b0;
         en_model[i][1] = 1'b0;
      end
      exp_count[0] = 0;
      exp_count[1] = 0;
      exp_fired[0] = 1'b0;
      exp_fired[1] = 1'b0;
   endtask

   // Unanchored search over the saved history plus this packet
   task automatic model_packet(input int s, input string payload);
      string buffer;
      int    plen;
      int    keep;
      int    c;
      int    j;
      bit    hit;
      if (!seen[s])
      begin
         // Unknown stream starts with empty history
         seen[s] = 1'b1;
         hist[s][0] = "";
         hist[s][1] = "";
      end
      for (c = 0; c < regex_pkg::NUM_CAT; c++)
      begin
         buffer = {hist[s][c], payload};
         plen = pat[c].len();
         hit = 1'b0;
         // Only matches that end inside this packet
         for (j = hist[s][c].len(); j < buffer.len(); j++)
         begin
            if (j + 1 >= plen && buffer.substr(j + 1 - plen, j) == pat[c])
            begin
               hit = 1'b1;
            end
         end
         if (en_model[s][c])
         begin
            exp_count[c] = exp_count[c] + int'(hit);
            exp_fired[c] = hit;
            keep = plen - 1;
            if (buffer.len() > keep)
            begin
               hist[s][c] = buffer.substr(buffer.len() - keep, buffer.len() - 1);
            end
            else
            begin
               hist[s][c] = buffer;
            end
         end
         else
         begin
            // Disabled stream keeps its old history
            exp_fired[c] = 1'b0;
         end
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      clear_model();
   endtask

   task automatic configure(input int s, input regex_pkg::cat_mask_t mask);
      @(negedge clk);
      cfg_we = 1'b1;
      cfg_stream = regex_pkg::stream_id_t'(s);
      cfg_enable = mask;
      @(negedge clk);
      cfg_we = 1'b0;
      en_model[s][0] = mask[0];
      en_model[s][1] = mask[1];
   endtask

   // One packet followed by a compare one cycle after eop
   task automatic send_packet(input int s, input string payload);
      int i;
      @(negedge clk);
      sop = 1'b1;
      stream_id = regex_pkg::stream_id_t'(s);
      @(negedge clk);
      sop = 1'b0;
      // State restore needs two more cycles
      repeat (2) @(negedge clk);
      for (i = 0; i < payload.len(); i++)
      begin
         char_vld = 1'b1;
         char_in = payload[i];
         @(negedge clk);
      end
      char_vld = 1'b0;
      // Gap lets the last accept reach the flag
      @(negedge clk);
      eop = 1'b1;
      @(negedge clk);
      eop = 1'b0;
      model_packet(s, payload);
      compare_outputs($sformatf("stream %0d packet '%s'", s, payload));
   endtask

   // Two hits in one packet count once and only in category A
   task automatic count_double_hit();
      configure(5, 2'b11);
      send_packet(5, {filler(), "abc", filler(), "abc", filler()});
      check_value("count_a after double hit", int'(count_a), 1);
      check_value("fired after double hit", int'(fired), 1);
   endtask

   // Split pattern joins within a stream but not across streams
   task automatic join_split_match();
      configure(7, 2'b11);
      send_packet(7, {filler(), "ne"});
      send_packet(7, {"edle", filler()});
      check_value("count_b after split match", int'(count_b), 1);
      configure(8, 2'b11);
      configure(9, 2'b11);
      send_packet(8, {filler(), "ne"});
      send_packet(9, {"edle", filler()});
      check_value("count_b after split over streams", int'(count_b), 1);
   endtask

   // Streams 3 and 40 alternate with their own partial matches
   task automatic interleave_streams();
      configure(3, 2'b11);
      configure(40, 2'b11);
      send_packet(3, {filler(), "ab"});
      send_packet(40, {filler(), "nee"});
      // Empty packet keeps the partial
      send_packet(3, "");
      send_packet(40, "dl");
      send_packet(3, {"c", filler()});
      send_packet(40, {"e", filler()});
      check_value("count_a after interleave", int'(count_a), 2);
      check_value("count_b after interleave", int'(count_b), 2);
   endtask

   // Disabled packets neither count nor save state
   task automatic mask_disabled_stream();
      configure(12, 2'b00);
      send_packet(12, {"abc", filler(), "needle"});
      configure(12, 2'b11);
      send_packet(12, filler());
      configure(12, 2'b00);
      send_packet(12, {filler(), "ab"});
      configure(12, 2'b11);
      send_packet(12, {"c", filler()});
      check_value("count_a after disabled partial", int'(count_a), 2);
   endtask

   // Reset forgets every stream
   task automatic forget_on_reset();
      configure(20, 2'b11);
      // Hit on A leaves fired[0] high going into reset
      send_packet(20, {"abc", filler(), "needl"});
      apply_reset();
      compare_outputs("after reset");
      configure(20, 2'b11);
      send_packet(20, {"e", filler()});
      check_value("count_b after reset", int'(count_b), 0);
   endtask

   initial
   begin
      rst_n = 1'b0;
      sop = 1'b0;
      stream_id = '0;
      char_vld = 1'b0;
      char_in = '0;
      eop = 1'b0;
      cfg_we = 1'b0;
      cfg_stream = '0;
      cfg_enable = '0;
      seed = 17545;
      errors = 0;
      pat[0] = "abc";
      pat[1] = "needle";
      apply_reset();
      compare_outputs("initial reset");
      count_double_hit();
      join_split_match();
      interleave_streams();
      mask_disabled_stream();
      forget_on_reset();
      if (errors == 0)
      begin
         $display("All checks passed");
      end
      else
      begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
verilog/regex_pkg.sv
verilog/shift_and_matcher.sv
verilog/stream_tracker.sv
verilog/regex_category.sv
verilog/regex_scan_top.sv
dv/regex_scan_chk.sv
dv/regex_scan_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the regex scanner testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/regex_scan_sim

# Compile with assertions on, top is the testbench
if ! verilator --binary --assert -j 0 --top-module regex_scan_tb -f sim.f -o regex_scan_sim; then
   echo "Verilator build failed"
   exit 1
fi

# Run and keep the log for the pass/fail search
"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Verdict comes from the log
if grep -q "Checks failed" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi

echo "Simulation passed"
exit 0
